//--- mem_test_pkg.sv
package mem_test_pkg;

    // ========================================
    // Address map
    // ========================================

    // Word address spanning the whole memory region
    localparam int ADDR_BITS = 12;

    // Address fields from the low end upward
    localparam int CHK_LOW_BITS = 5;
    localparam int CHK_MID_BITS = 4;
    localparam int CHK_HIGH_BITS = 3;

    // Checked index is {high, low}, one tag RAM entry each
    localparam int CHK_IDX_BITS = CHK_HIGH_BITS + CHK_LOW_BITS;
    localparam int CHK_ENTRIES = 1 << CHK_IDX_BITS;

    // Reads force this bit low and writes force it high
    localparam int CONFLICT_BIT = 2;

    // ========================================
    // Data, tags and counters
    // ========================================

    localparam int DATA_BITS = 64;
    localparam int TAG_BITS = 16;

    // Bytes of a data word that make up the tag
    localparam int TAG_LOW_BYTE = 0;
    localparam int TAG_HIGH_BYTE = 5;

    localparam int COUNT_BITS = 24;

    // Record buffer, threshold counted in free entries
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_THRESHOLD = 4;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [CHK_IDX_BITS-1:0] chk_idx_t;
    typedef logic [COUNT_BITS-1:0] count_t;
    typedef logic [31:0] lfsr_t;
    typedef logic [FIFO_PTR_BITS-1:0] fifo_ptr_t;
    typedef logic [FIFO_PTR_BITS:0] fifo_count_t;

    // LFSR start values, never zero
    localparam lfsr_t ADDR_SEED = 32'h0000_2721;
    localparam lfsr_t DATA_LO_SEED = 32'h0000_0001;
    localparam lfsr_t DATA_HI_SEED = 32'h0000_0002;

    // Run control
    typedef enum logic [1:0]
    {
        RUN_IDLE,
        RUN_ACTIVE,
        RUN_TERMINATE,
        RUN_ERROR
    } run_state_t;

endpackage

//--- rec_if.sv
`timescale 1ns/10ps

interface rec_if;

    // Handshake
    logic valid;
    logic ready;

    // Record payload
    logic is_write;
    mem_test_pkg::chk_idx_t idx;
    mem_test_pkg::tag_t tag;

    // Back-pressure toward the sender
    logic almost_full;

    modport sender
    (
        output valid, is_write, idx, tag,
        input  ready, almost_full
    );

    modport receiver
    (
        input  valid, is_write, idx, tag,
        output ready, almost_full
    );

endinterface

//--- traffic_gen.sv
`timescale 1ns/10ps

module traffic_gen
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  mem_test_pkg::count_t run_cycles,
    input  logic enable_reads,
    input  logic enable_writes,
    input  logic enable_rw_conflicts,
    input  mem_test_pkg::data_t wb_dat_r,
    input  logic wb_ack,
    input  logic check_error,
    input  logic drained,

    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output mem_test_pkg::addr_t wb_adr,
    output mem_test_pkg::data_t wb_dat_w,
    output logic busy,
    output mem_test_pkg::count_t rd_count,
    output mem_test_pkg::count_t wr_count,

    rec_if.sender rec
);

    // 32-bit Fibonacci LFSR step, taps 32 22 2 1
    function automatic mem_test_pkg::lfsr_t lfsr_next(mem_test_pkg::lfsr_t r);
        return {r[30:0], r[31] ^ r[21] ^ r[1] ^ r[0]};
    endfunction

    // Only addresses with a zero middle field have a tag
    function automatic logic addr_is_checked(mem_test_pkg::addr_t a);
        return a[mem_test_pkg::CHK_LOW_BITS +: mem_test_pkg::CHK_MID_BITS] == '0;
    endfunction

    // High field on top of low field
    function automatic mem_test_pkg::chk_idx_t addr_to_idx(mem_test_pkg::addr_t a);
        return {a[mem_test_pkg::ADDR_BITS-1 -: mem_test_pkg::CHK_HIGH_BITS],
                a[mem_test_pkg::CHK_LOW_BITS-1:0]};
    endfunction

    function automatic mem_test_pkg::tag_t data_to_tag(mem_test_pkg::data_t d);
        return {d[8 * mem_test_pkg::TAG_HIGH_BYTE +: 8],
                d[8 * mem_test_pkg::TAG_LOW_BYTE +: 8]};
    endfunction

    mem_test_pkg::run_state_t state;
    mem_test_pkg::count_t cycles_rem;

    // Configuration held for the whole run
    logic cfg_reads;
    logic cfg_writes;
    logic cfg_conflicts;

    // Random sources
    mem_test_pkg::lfsr_t addr_lfsr;
    mem_test_pkg::lfsr_t data_lo_lfsr;
    mem_test_pkg::lfsr_t data_hi_lfsr;

    logic pick_write;
    logic can_open;
    logic end_ok;
    logic ack_seen;
    mem_test_pkg::addr_t next_adr;

    // ========================================
    // Run control
    // ========================================

    // Nothing left on the bus, in the hand-off or in the checker
    assign end_ok = !wb_cyc && !rec.valid && drained;
    assign busy = (state != mem_test_pkg::RUN_IDLE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= mem_test_pkg::RUN_IDLE;
            cycles_rem <= '0;
            cfg_reads <= 1'b0;
            cfg_writes <= 1'b0;
            cfg_conflicts <= 1'b0;
        end
        else
        begin
            case (state)
                mem_test_pkg::RUN_IDLE:
                begin
                    // Latch the run setup
                    if (start)
                    begin
                        state <= mem_test_pkg::RUN_ACTIVE;
                        cycles_rem <= run_cycles;
                        cfg_reads <= enable_reads;
                        cfg_writes <= enable_writes;
                        cfg_conflicts <= enable_rw_conflicts;
                    end
                end

                mem_test_pkg::RUN_ACTIVE:
                begin
                    if (check_error)
                    begin
                        state <= mem_test_pkg::RUN_ERROR;
                    end
                    else if (cycles_rem == '0)
                    begin
                        state <= mem_test_pkg::RUN_TERMINATE;
                    end
                    else
                    begin
                        cycles_rem <= cycles_rem - mem_test_pkg::count_t'(1);
                    end
                end

                default:
                begin
                    // Wait for the open bus cycle and the checker
                    if (end_ok)
                    begin
                        state <= mem_test_pkg::RUN_IDLE;
                    end
                end
            endcase
        end
    end

    // ========================================
    // Random address and data
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            addr_lfsr <= mem_test_pkg::ADDR_SEED;
            data_lo_lfsr <= mem_test_pkg::DATA_LO_SEED;
            data_hi_lfsr <= mem_test_pkg::DATA_HI_SEED;
        end
        else
        begin
            addr_lfsr <= lfsr_next(addr_lfsr);
            data_lo_lfsr <= lfsr_next(data_lo_lfsr);
            data_hi_lfsr <= lfsr_next(data_hi_lfsr);
        end
    end

    always_comb
    begin
        // Top LFSR bit picks the direction when both are enabled
        pick_write = cfg_writes && (!cfg_reads || addr_lfsr[31]);
        next_adr = mem_test_pkg::addr_t'(addr_lfsr);

        // Keep reads and writes on disjoint halves
        if (!cfg_conflicts)
        begin
            next_adr[mem_test_pkg::CONFLICT_BIT] = pick_write;
        end

        // Bus idle for a cycle, buffer has room, hand-off free
        can_open = (state == mem_test_pkg::RUN_ACTIVE) && (cycles_rem != '0) &&
                   !check_error && (cfg_reads || cfg_writes) &&
                   !rec.almost_full && !wb_cyc && (!rec.valid || rec.ready);
    end

    // ========================================
    // Wishbone master and record hand-off
    // ========================================

    assign ack_seen = wb_cyc && wb_ack;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            rec.valid <= 1'b0;
            rd_count <= '0;
            wr_count <= '0;
        end
        else
        begin
            if (rec.valid && rec.ready)
            begin
                rec.valid <= 1'b0;
            end

            if (ack_seen)
            begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                if (wb_we)
                begin
                    wr_count <= wr_count + mem_test_pkg::count_t'(1);
                end
                else
                begin
                    rd_count <= rd_count + mem_test_pkg::count_t'(1);
                end
                // Unchecked addresses produce no record
                rec.valid <= addr_is_checked(wb_adr);
            end
            else if (can_open)
            begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
            end

            if (start && !busy)
            begin
                rd_count <= '0;
                wr_count <= '0;
            end
        end
    end

    // Request payload and record payload
    always_ff @(posedge clk)
    begin
        if (can_open)
        begin
            wb_we <= pick_write;
            wb_adr <= next_adr;
            wb_dat_w <= {data_hi_lfsr, data_lo_lfsr};
        end

        if (ack_seen)
        begin
            rec.is_write <= wb_we;
            rec.idx <= addr_to_idx(wb_adr);
            rec.tag <= wb_we ? data_to_tag(wb_dat_w) : data_to_tag(wb_dat_r);
        end
    end

    // Strobe only inside a bus cycle
    assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc);

    // Request held steady until the slave acks
    assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) &&
                              $stable(wb_dat_w));

endmodule

//--- record_fifo.sv
`timescale 1ns/10ps

module record_fifo
(
    input logic clk,
    input logic reset,

    rec_if.receiver upstream,
    rec_if.sender downstream
);

    // Record storage, one array per field
    logic mem_is_write [mem_test_pkg::FIFO_DEPTH];
    mem_test_pkg::chk_idx_t mem_idx [mem_test_pkg::FIFO_DEPTH];
    mem_test_pkg::tag_t mem_tag [mem_test_pkg::FIFO_DEPTH];

    mem_test_pkg::fifo_ptr_t wr_ptr;
    mem_test_pkg::fifo_ptr_t rd_ptr;
    mem_test_pkg::fifo_count_t count;

    logic push;
    logic pop;

    assign upstream.ready = (count != mem_test_pkg::fifo_count_t'(mem_test_pkg::FIFO_DEPTH));
    assign push = upstream.valid && upstream.ready;
    assign pop = downstream.valid && downstream.ready;

    // Low on free space, or the checker is still clearing its RAM
    assign upstream.almost_full =
        (count >= mem_test_pkg::fifo_count_t'(mem_test_pkg::FIFO_DEPTH -
                                              mem_test_pkg::FIFO_THRESHOLD)) ||
        downstream.almost_full;

    // Head of the buffer
    assign downstream.valid = (count != '0);
    assign downstream.is_write = mem_is_write[rd_ptr];
    assign downstream.idx = mem_idx[rd_ptr];
    assign downstream.tag = mem_tag[rd_ptr];

    // Pointers wrap on the power of two depth
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + mem_test_pkg::fifo_ptr_t'(1);
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + mem_test_pkg::fifo_ptr_t'(1);
            end
            if (push && !pop)
            begin
                count <= count + mem_test_pkg::fifo_count_t'(1);
            end
            else if (pop && !push)
            begin
                count <= count - mem_test_pkg::fifo_count_t'(1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem_is_write[wr_ptr] <= upstream.is_write;
            mem_idx[wr_ptr] <= upstream.idx;
            mem_tag[wr_ptr] <= upstream.tag;
        end
    end

    // Almost-full keeps the producer from ever offering to a full buffer
    assert property (@(posedge clk) disable iff (reset)
        upstream.valid |-> count != mem_test_pkg::fifo_count_t'(mem_test_pkg::FIFO_DEPTH));

endmodule

//--- tag_checker.sv
`timescale 1ns/10ps

module tag_checker
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic enable_checker,

    rec_if.receiver rec,

    output mem_test_pkg::count_t checked_count,
    output logic error,
    output logic drained
);

    // One tag per checked word
    mem_test_pkg::tag_t tag_ram [mem_test_pkg::CHK_ENTRIES];

    // Clear sequencer
    logic init_busy;
    mem_test_pkg::chk_idx_t init_idx;

    logic cfg_checker;
    logic accept;

    // Compare stage
    logic cmp_valid;
    mem_test_pkg::tag_t cmp_expected;
    mem_test_pkg::tag_t cmp_observed;

    // Hold everything off until the RAM is cleared
    assign rec.ready = !init_busy;
    assign rec.almost_full = init_busy;
    assign accept = rec.valid && rec.ready;

    // Nothing waiting and no compare outstanding
    assign drained = !rec.valid && !cmp_valid;

    // ========================================
    // RAM clear after reset
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_busy <= 1'b1;
            init_idx <= '0;
        end
        else if (init_busy)
        begin
            init_idx <= init_idx + mem_test_pkg::chk_idx_t'(1);
            // Last entry written this cycle
            if (init_idx == '1)
            begin
                init_busy <= 1'b0;
            end
        end
    end

    // Single write port, registered read
    always_ff @(posedge clk)
    begin
        if (init_busy)
        begin
            tag_ram[init_idx] <= '0;
        end
        else if (accept && rec.is_write)
        begin
            tag_ram[rec.idx] <= rec.tag;
        end

        cmp_expected <= tag_ram[rec.idx];
        cmp_observed <= rec.tag;
    end

    // ========================================
    // Compare, count and error
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cmp_valid <= 1'b0;
            cfg_checker <= 1'b0;
            checked_count <= '0;
            error <= 1'b0;
        end
        else
        begin
            cmp_valid <= accept && !rec.is_write;

            if (cmp_valid)
            begin
                checked_count <= checked_count + mem_test_pkg::count_t'(1);
                // Sticky until the next run
                if (cfg_checker && (cmp_expected != cmp_observed))
                begin
                    error <= 1'b1;
                end
            end

            if (start)
            begin
                cfg_checker <= enable_checker;
                checked_count <= '0;
                error <= 1'b0;
            end
        end
    end

    // Producer back-pressure keeps the buffer empty during the clear
    assert property (@(posedge clk) disable iff (reset) init_busy |-> !rec.valid);

endmodule

//--- mem_test_top.sv
`timescale 1ns/10ps

module mem_test_top
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  mem_test_pkg::count_t run_cycles,
    input  logic enable_reads,
    input  logic enable_writes,
    input  logic enable_checker,
    input  logic enable_rw_conflicts,
    input  mem_test_pkg::data_t wb_dat_r,
    input  logic wb_ack,

    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output mem_test_pkg::addr_t wb_adr,
    output mem_test_pkg::data_t wb_dat_w,
    output logic busy,
    output logic error,
    output mem_test_pkg::count_t rd_count,
    output mem_test_pkg::count_t wr_count,
    output mem_test_pkg::count_t checked_count
);

    // Producer to buffer, buffer to checker
    rec_if rec_in ();
    rec_if rec_out ();

    logic drained;

    traffic_gen gen
    (
        .clk,
        .reset,
        .start,
        .run_cycles,
        .enable_reads,
        .enable_writes,
        .enable_rw_conflicts,
        .wb_dat_r,
        .wb_ack,
        .check_error(error),
        .drained,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_w,
        .busy,
        .rd_count,
        .wr_count,
        .rec(rec_in)
    );

    record_fifo fifo
    (
        .clk,
        .reset,
        .upstream(rec_in),
        .downstream(rec_out)
    );

    tag_checker tag_chk
    (
        .clk,
        .reset,
        .start,
        .enable_checker,
        .rec(rec_out),
        .checked_count,
        .error,
        .drained
    );

endmodule

//--- tb_wb_memory.sv
`timescale 1ns/10ps

module tb_wb_memory
(
    input  logic clk,
    input  logic reset,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  mem_test_pkg::addr_t wb_adr,
    input  mem_test_pkg::data_t wb_dat_w,
    input  logic [1:0] wait_cycles,
    input  logic corrupt_req,

    output mem_test_pkg::data_t wb_dat_r,
    output logic wb_ack
);

    localparam int WORDS = 1 << mem_test_pkg::ADDR_BITS;

    // Whole word-addressed region
    mem_test_pkg::data_t mem [WORDS];

    // Wait state tracking for the open request
    logic in_req;
    logic [1:0] req_wait;
    logic [1:0] waited;

    // Corruption requested but no read returned yet
    logic flip_pending;

    initial
    begin
        for (int i = 0; i < WORDS; i++)
        begin
            mem[i] = '0;
        end
    end

    always @(posedge clk)
    begin
        logic [1:0] cur_wait;
        logic flip;

        // Delay is fixed at the first cycle of each request
        cur_wait = in_req ? req_wait : wait_cycles;
        flip = flip_pending || corrupt_req;

        if (reset)
        begin
            wb_ack <= 1'b0;
            wb_dat_r <= '0;
            in_req <= 1'b0;
            req_wait <= '0;
            waited <= '0;
            flip_pending <= 1'b0;
        end
        else
        begin
            // Ack lasts one cycle
            wb_ack <= 1'b0;
            if (corrupt_req)
            begin
                flip_pending <= 1'b1;
            end

            if (wb_cyc && wb_stb && !wb_ack)
            begin
                if (waited >= cur_wait)
                begin
                    wb_ack <= 1'b1;
                    in_req <= 1'b0;
                    waited <= '0;
                    if (wb_we)
                    begin
                        mem[wb_adr] <= wb_dat_w;
                    end
                    else
                    begin
                        // Byte 0 inverted on a corrupted read
                        wb_dat_r <= mem[wb_adr] ^
                                    (flip ? mem_test_pkg::data_t'(8'hff) : '0);
                        if (flip)
                        begin
                            flip_pending <= 1'b0;
                        end
                    end
                end
                else
                begin
                    in_req <= 1'b1;
                    req_wait <= cur_wait;
                    waited <= waited + 2'd1;
                end
            end
        end
    end

endmodule

//--- tb_mem_test.sv
`timescale 1ns/10ps

module tb_mem_test;

    localparam logic [31:0] SEED = 32'hc5342fd1;
    localparam int NUM_RUNS = 8;
    localparam int FAULT_RUN_CYCLES = 20000;
    localparam int CLEAR_CYCLES = 256;

    logic clk;
    logic reset;
    logic start;
    mem_test_pkg::count_t run_cycles;
    logic enable_reads;
    logic enable_writes;
    logic enable_checker;
    logic enable_rw_conflicts;
    mem_test_pkg::data_t wb_dat_r;
    logic wb_ack;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    mem_test_pkg::addr_t wb_adr;
    mem_test_pkg::data_t wb_dat_w;
    logic busy;
    logic error;
    mem_test_pkg::count_t rd_count;
    mem_test_pkg::count_t wr_count;
    mem_test_pkg::count_t checked_count;

    // Slave controls
    logic [1:0] wait_cycles;
    logic corrupt_req;

    // Two random streams, configuration and wait states
    logic [31:0] cfg_rng;
    logic [31:0] wait_rng;

    int unsigned cycle_count;
    int unsigned cycle_limit;

    // Reference model of the bus traffic
    mem_test_pkg::count_t model_rd;
    mem_test_pkg::count_t model_wr;
    mem_test_pkg::count_t model_chk;
    logic written [mem_test_pkg::CHK_ENTRIES];
    logic cur_conflicts;
    logic arm_corrupt;
    logic corrupted;

    // Request seen waiting at the previous falling edge
    logic prev_wait;
    mem_test_pkg::addr_t prev_adr;
    logic prev_we;
    mem_test_pkg::data_t prev_dat;

    // Run list, config bits are reads, writes, checker, conflicts
    int unsigned run_len [NUM_RUNS];
    logic [3:0] run_cfg [NUM_RUNS];
    int unsigned total_len;
    int unsigned elapsed;

    mem_test_top dut
    (
        .clk,
        .reset,
        .start,
        .run_cycles,
        .enable_reads,
        .enable_writes,
        .enable_checker,
        .enable_rw_conflicts,
        .wb_dat_r,
        .wb_ack,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_w,
        .busy,
        .error,
        .rd_count,
        .wr_count,
        .checked_count
    );

    tb_wb_memory slave
    (
        .clk,
        .reset,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_w,
        .wait_cycles,
        .corrupt_req,
        .wb_dat_r,
        .wb_ack
    );

    // ========================================
    // Helpers
    // ========================================

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Middle field zero means the word has a tag
    function automatic logic is_checked(mem_test_pkg::addr_t a);
        int unsigned v;
        v = a;
        v = v >> mem_test_pkg::CHK_LOW_BITS;
        return (v % (1 << mem_test_pkg::CHK_MID_BITS)) == 0;
    endfunction

    // High field above low field
    function automatic mem_test_pkg::chk_idx_t index_of(mem_test_pkg::addr_t a);
        int unsigned v;
        int unsigned high;
        int unsigned low;
        v = a;
        high = v >> (mem_test_pkg::CHK_LOW_BITS + mem_test_pkg::CHK_MID_BITS);
        low = v % (1 << mem_test_pkg::CHK_LOW_BITS);
        return mem_test_pkg::chk_idx_t'((high << mem_test_pkg::CHK_LOW_BITS) + low);
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_count(string name, mem_test_pkg::count_t actual,
                               mem_test_pkg::count_t expected);
        if (actual !== expected)
        begin
            report_failure($sformatf("mismatch at %0t: %s = %0d, expected %0d",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected)
        begin
            report_failure($sformatf("mismatch at %0t: %s = %b, expected %b",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_addr(string name, mem_test_pkg::addr_t actual,
                              mem_test_pkg::addr_t expected);
        if (actual !== expected)
        begin
            report_failure($sformatf("mismatch at %0t: %s = %0h, expected %0h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_data(string name, mem_test_pkg::data_t actual,
                              mem_test_pkg::data_t expected);
        if (actual !== expected)
        begin
            report_failure($sformatf("mismatch at %0t: %s = %0h, expected %0h",
                                     $time, name, actual, expected));
        end
    endtask

    // Start one run and wait for busy to fall
    task automatic do_run(input int unsigned cycles, input logic [3:0] cfg,
                          output int unsigned len);
        @(negedge clk);
        run_cycles = mem_test_pkg::count_t'(cycles);
        enable_reads = cfg[0];
        enable_writes = cfg[1];
        enable_checker = cfg[2];
        enable_rw_conflicts = cfg[3];
        cur_conflicts = cfg[3];
        model_rd = '0;
        model_wr = '0;
        model_chk = '0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag("busy", busy, 1'b1);
        len = 1;
        while (busy)
        begin
            @(negedge clk);
            len++;
        end
    endtask

    task automatic check_results(logic [3:0] cfg, logic exp_error);
        check_flag("error", error, exp_error);
        check_count("rd_count", rd_count, model_rd);
        check_count("wr_count", wr_count, model_wr);
        check_count("checked_count", checked_count, model_chk);
        // Disabled directions stay off the bus
        if (!cfg[0])
        begin
            check_count("bus reads", model_rd, '0);
        end
        if (!cfg[1])
        begin
            check_count("bus writes", model_wr, '0);
        end
    endtask

    // ========================================
    // Clock, timeout and bus monitor
    // ========================================

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            report_failure("timeout: the test did not finish within the cycle limit");
        end
    end

    always @(negedge clk)
    begin
        mem_test_pkg::addr_t want_adr;

        // New wait state draw every cycle
        wait_rng = xorshift(wait_rng);
        wait_cycles = wait_rng[1:0];
        corrupt_req = 1'b0;

        if (!reset)
        begin
            if (wb_cyc && !busy)
            begin
                report_failure("a bus cycle is open while busy is low");
            end

            // Request must hold until acked
            if (prev_wait)
            begin
                check_flag("wb_stb", wb_stb, 1'b1);
                check_flag("wb_we", wb_we, prev_we);
                check_addr("wb_adr", wb_adr, prev_adr);
                check_data("wb_dat_w", wb_dat_w, prev_dat);
            end

            // Reads on bit 2 low, writes on bit 2 high
            if (wb_cyc && wb_stb && !cur_conflicts)
            begin
                want_adr = wb_adr;
                want_adr[mem_test_pkg::CONFLICT_BIT] = wb_we;
                check_addr("wb_adr", wb_adr, want_adr);
            end

            // Completed transfer
            if (wb_cyc && wb_ack)
            begin
                if (wb_we)
                begin
                    model_wr++;
                    if (is_checked(wb_adr))
                    begin
                        written[index_of(wb_adr)] = 1'b1;
                    end
                end
                else
                begin
                    model_rd++;
                    if (is_checked(wb_adr))
                    begin
                        model_chk++;
                    end
                end
            end

            // Corrupt one read of a word that holds a written tag
            if (arm_corrupt && wb_cyc && wb_stb && !wb_we && !wb_ack &&
                is_checked(wb_adr) && written[index_of(wb_adr)])
            begin
                corrupt_req = 1'b1;
                arm_corrupt = 1'b0;
                corrupted = 1'b1;
            end

            prev_wait = wb_cyc && wb_stb && !wb_ack;
            prev_adr = wb_adr;
            prev_we = wb_we;
            prev_dat = wb_dat_w;
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        run_cycles = '0;
        enable_reads = 1'b0;
        enable_writes = 1'b0;
        enable_checker = 1'b0;
        enable_rw_conflicts = 1'b0;
        wait_cycles = '0;
        corrupt_req = 1'b0;
        cfg_rng = SEED;
        wait_rng = {SEED[15:0], SEED[31:16]};
        cycle_count = 0;
        model_rd = '0;
        model_wr = '0;
        model_chk = '0;
        cur_conflicts = 1'b1;
        arm_corrupt = 1'b0;
        corrupted = 1'b0;
        prev_wait = 1'b0;
        for (int i = 0; i < mem_test_pkg::CHK_ENTRIES; i++)
        begin
            written[i] = 1'b0;
        end

        // Random run lengths and configurations
        total_len = 2 * FAULT_RUN_CYCLES;
        for (int i = 0; i < NUM_RUNS; i++)
        begin
            cfg_rng = xorshift(cfg_rng);
            run_len[i] = 500 + cfg_rng % 2000;
            cfg_rng = xorshift(cfg_rng);
            run_cfg[i] = cfg_rng[3:0];
            total_len += run_len[i];
        end
        cycle_limit = 5 * total_len + CLEAR_CYCLES;

        repeat (10) @(negedge clk);
        reset = 1'b0;

        // Idle state after reset
        @(negedge clk);
        check_flag("wb_cyc", wb_cyc, 1'b0);
        check_flag("wb_stb", wb_stb, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("error", error, 1'b0);
        check_count("rd_count", rd_count, '0);
        check_count("wr_count", wr_count, '0);
        check_count("checked_count", checked_count, '0);

        // Honest memory, random setups
        for (int i = 0; i < NUM_RUNS; i++)
        begin
            do_run(run_len[i], run_cfg[i], elapsed);
            check_results(run_cfg[i], 1'b0);
        end

        // Corrupted read with the checker on stops the run early
        arm_corrupt = 1'b1;
        corrupted = 1'b0;
        do_run(FAULT_RUN_CYCLES, 4'b1111, elapsed);
        if (!corrupted)
        begin
            report_failure("no read of a written checked address was corrupted");
        end
        check_results(4'b1111, 1'b1);
        if (elapsed >= FAULT_RUN_CYCLES)
        begin
            report_failure("the run did not end early after a tag error");
        end

        // Same fault with the checker off
        arm_corrupt = 1'b1;
        corrupted = 1'b0;
        do_run(FAULT_RUN_CYCLES, 4'b1011, elapsed);
        if (!corrupted)
        begin
            report_failure("no read of a written checked address was corrupted");
        end
        check_results(4'b1011, 1'b0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- project.f
mem_test_pkg.sv
rec_if.sv
traffic_gen.sv
record_fifo.sv
tag_checker.sv
mem_test_top.sv
tb_wb_memory.sv
tb_mem_test.sv

//--- Bender.yml
package:
  name: mem_test

sources:
  - mem_test_pkg.sv
  - rec_if.sv
  - traffic_gen.sv
  - record_fifo.sv
  - tag_checker.sv
  - mem_test_top.sv
  - target: test
    files:
      - tb_wb_memory.sv
      - tb_mem_test.sv
